// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = capture_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+hw
hw/capture_pkg.sv
hw/sample_fifo.sv
hw/capture_ctrl.sv
hw/sample_packer.sv
hw/byte_unpacker.sv
hw/capture_top.sv
sim/capture_checker.sv
sim/capture_tb.sv

// File: hw/byte_unpacker.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module byte_unpacker import capture_pkg::*; (
    input  logic         clk_i,
    input  logic         reset,
    input  logic         read_en_i,
    input  logic         low_res_i,
    input  fifo_status_t word_status_i,
    input  word_t        word_i,
    output logic         word_rd_o,
    output byte_t        data_o,
    output logic         valid_o
);

    localparam int MID_LAST  = `CAP_WORD_W / 8 - 1;        // last whole byte of the first word
    localparam int PAIR_LAST = `CAP_BYTES_PER_PAIR - 1;
    localparam int LOW_LAST  = `CAP_SAMPLES_PER_WORD - 1;

    logic [3:0] byte_idx;
    logic [3:0] nib_q;      // low nibble of the first word of a pair
    logic       active;
    logic       pop;
    logic       wrap;
    byte_t      byte_sel;
    byte_t      data_q;
    logic       valid_q;

    assign active = read_en_i & ~word_status_i.empty;

    always_comb begin
        if (low_res_i) begin
            pop  = (byte_idx >= 4'(LOW_LAST));
            wrap = pop;
        end else begin
            pop  = (byte_idx == 4'(MID_LAST)) || (byte_idx == 4'(PAIR_LAST));
            wrap = (byte_idx == 4'(PAIR_LAST));
        end
    end

    assign word_rd_o = active & pop;

    always_comb begin
        if (low_res_i) begin
            case (byte_idx)   // top 8 bits of each sample
                4'd0:    byte_sel = word_i[35:28];
                4'd1:    byte_sel = word_i[23:16];
                4'd2:    byte_sel = word_i[11:4];
                default: byte_sel = '0;
            endcase
        end else begin
            case (byte_idx)
                4'd0:    byte_sel = word_i[35:28];
                4'd1:    byte_sel = word_i[27:20];
                4'd2:    byte_sel = word_i[19:12];
                4'd3:    byte_sel = word_i[11:4];
                4'd4:    byte_sel = {nib_q, word_i[35:32]};   // straddles both words
                4'd5:    byte_sel = word_i[31:24];
                4'd6:    byte_sel = word_i[23:16];
                4'd7:    byte_sel = word_i[15:8];
                4'd8:    byte_sel = word_i[7:0];
                default: byte_sel = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) begin
            byte_idx <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= active;
            if (active)
                byte_idx <= wrap ? 4'd0 : byte_idx + 4'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (active) data_q <= byte_sel;
        if (active && !low_res_i && (byte_idx == 4'(MID_LAST)))
            nib_q <= word_i[3:0];
    end

    assign data_o  = data_q;
    assign valid_o = valid_q;

endmodule

// File: hw/capture_ctrl.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module capture_ctrl import capture_pkg::*; (
    input  logic           clk_i,
    input  logic           reset,
    input  logic           arm_i,
    input  logic           capture_go_i,
    input  logic           write_mask_i,
    input  sample_t        datain_i,
    input  capture_cfg_t   cfg_i,
    input  fifo_status_t   sample_status_i,
    input  logic           packer_idle_i,
    output logic           fifo_clear_o,
    output logic           sample_wr_o,
    output sample_t        sample_din_o,
    output logic           discard_o,
    output capture_state_t state_o,
    output logic           capture_done_o
);

    localparam int CNT_W = `CAP_COUNT_W + 1;   // room for the rounded-up stop count

    capture_state_t          state;
    logic                    arm_q;
    logic                    arm_edge;
    logic                    armed;   // no presamples, idle waits for the trigger
    logic [`CAP_DECIM_W-1:0] decim_ctr;
    logic                    eligible;
    logic [`CAP_COUNT_W-1:0] held_cnt;
    logic [CNT_W-1:0]        trig_cnt;
    logic [CNT_W-1:0]        stop_cnt;
    logic [CNT_W-1:0]        kept_total;
    logic [1:0]              kept_mod3;
    logic                    stop_reached;
    logic                    write_state;
    logic                    done_q;

    assign arm_edge     = arm_i & ~arm_q;
    assign fifo_clear_o = arm_edge;
    assign eligible     = (decim_ctr == cfg_i.decimation);

    // samples written and not discarded in this run
    assign kept_total   = CNT_W'(held_cnt) + trig_cnt;
    // whole words only, so the packer is never left with a partial word
    assign stop_reached = (kept_total >= stop_cnt) && (kept_mod3 == 2'd0);

    assign write_state = (state == ST_PRE_FILL) || (state == ST_PRE_FULL) ||
                         ((state == ST_TRIGGERED) && !stop_reached);

    assign sample_wr_o  = eligible & write_mask_i & write_state & ~arm_edge &
                          ~sample_status_i.full;
    assign sample_din_o = datain_i;
    assign discard_o    = sample_wr_o & (state == ST_PRE_FULL);   // drop the oldest presample

    assign state_o        = state;
    assign capture_done_o = done_q;

    // decimation counter, restarted by the arm edge
    always_ff @(posedge clk_i) begin
        if (reset) begin
            arm_q     <= arm_i;   // an arm held through reset is not an edge
            decim_ctr <= '0;
        end else begin
            arm_q <= arm_i;
            if (arm_edge || eligible)
                decim_ctr <= '0;
            else
                decim_ctr <= decim_ctr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) begin
            state     <= ST_IDLE;
            armed     <= 1'b0;
            held_cnt  <= '0;
            trig_cnt  <= '0;
            stop_cnt  <= '0;
            kept_mod3 <= '0;
            done_q    <= 1'b0;
        end else if (arm_edge) begin
            held_cnt  <= '0;
            trig_cnt  <= '0;
            kept_mod3 <= '0;
            done_q    <= 1'b0;
            // M rounded up to a multiple of three
            stop_cnt  <= (({1'b0, cfg_i.max_samples} + CNT_W'(2)) / CNT_W'(3)) * CNT_W'(3);
            if (cfg_i.presamples != '0) begin
                state <= ST_PRE_FILL;
                armed <= 1'b0;
            end else begin
                state <= ST_IDLE;
                armed <= 1'b1;
            end
        end else begin
            if (sample_wr_o && !discard_o)
                kept_mod3 <= (kept_mod3 == 2'd2) ? 2'd0 : kept_mod3 + 2'd1;

            case (state)
                ST_IDLE: begin
                    if (armed && capture_go_i) begin
                        state <= ST_TRIGGERED;
                        armed <= 1'b0;
                    end
                end
                ST_PRE_FILL: begin
                    if (sample_wr_o) held_cnt <= held_cnt + 1'b1;
                    // trigger edge still writes as a presample
                    if (capture_go_i)
                        state <= ST_TRIGGERED;
                    else if (sample_wr_o && (held_cnt + 1'b1 == cfg_i.presamples))
                        state <= ST_PRE_FULL;
                end
                ST_PRE_FULL: begin
                    if (capture_go_i) state <= ST_TRIGGERED;
                end
                ST_TRIGGERED: begin
                    if (sample_wr_o) trig_cnt <= trig_cnt + 1'b1;
                    if (stop_reached) state <= ST_DONE;
                end
                ST_DONE: begin
                    // let the packer drain the sample FIFO and flush its last word
                    if (sample_status_i.empty && packer_idle_i) begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: hw/capture_defs.svh
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// ADC sample and packed word widths
`define CAP_SAMPLE_W          12
`define CAP_WORD_W            36
`define CAP_SAMPLES_PER_WORD  3

// FIFO depths in entries
`define CAP_SAMPLE_DEPTH      64
`define CAP_WORD_DEPTH        256

// capture setting widths
`define CAP_DECIM_W           13
`define CAP_COUNT_W           16

// two full-resolution words leave as nine bytes
`define CAP_BYTES_PER_PAIR    9

`endif

// File: hw/capture_pkg.sv
`include "capture_defs.svh"

package capture_pkg;

    typedef logic [`CAP_SAMPLE_W-1:0] sample_t;

    // three samples, oldest one in the top bits
    typedef logic [`CAP_WORD_W-1:0] word_t;

    typedef logic [7:0] byte_t;

    // static capture setting, held stable while a run is active
    typedef struct packed {
        logic [`CAP_DECIM_W-1:0] decimation;   // keep every (D+1)-th sample
        logic [`CAP_COUNT_W-1:0] presamples;
        logic [`CAP_COUNT_W-1:0] max_samples;
    } capture_cfg_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRE_FILL,
        ST_PRE_FULL,
        ST_TRIGGERED,
        ST_DONE
    } capture_state_t;

    typedef struct packed {
        logic empty;
        logic full;
    } fifo_status_t;

endpackage

// File: hw/capture_top.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module capture_top import capture_pkg::*; (
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  sample_t      adc_datain_i,
    input  logic         adc_write_mask_i,
    input  logic         arm_i,
    input  logic         adc_capture_go_i,
    input  capture_cfg_t cfg_i,
    input  logic         low_res_i,
    input  logic         read_en_i,
    output byte_t        read_data_o,
    output logic         read_valid_o,
    output logic         read_empty_o,
    output logic         capture_done_o
);

    logic           fifo_clear;
    logic           path_reset;
    logic           sample_wr;
    sample_t        sample_din;
    logic           discard;
    logic           packer_rd;
    logic           sample_rd;
    sample_t        sample_dout;
    fifo_status_t   sample_status;
    capture_state_t state;
    logic           packer_idle;
    logic           word_wr;
    word_t          word_din;
    logic           word_rd;
    word_t          word_dout;
    fifo_status_t   word_status;

    assign sample_rd    = discard | packer_rd;   // never both, see capture_ctrl states
    assign path_reset   = reset | fifo_clear;    // arming also drops partial words and bytes
    assign read_empty_o = word_status.empty;

    capture_ctrl u_ctrl (
        .clk_i           (adc_sampleclk),
        .reset           (reset),
        .arm_i           (arm_i),
        .capture_go_i    (adc_capture_go_i),
        .write_mask_i    (adc_write_mask_i),
        .datain_i        (adc_datain_i),
        .cfg_i           (cfg_i),
        .sample_status_i (sample_status),
        .packer_idle_i   (packer_idle),
        .fifo_clear_o    (fifo_clear),
        .sample_wr_o     (sample_wr),
        .sample_din_o    (sample_din),
        .discard_o       (discard),
        .state_o         (state),
        .capture_done_o  (capture_done_o)
    );

    sample_fifo #(.payload_t(sample_t), .DEPTH(`CAP_SAMPLE_DEPTH)) u_sample_fifo (
        .clk_i    (adc_sampleclk),
        .reset    (reset),
        .clear_i  (fifo_clear),
        .wr_en_i  (sample_wr),
        .din_i    (sample_din),
        .rd_en_i  (sample_rd),
        .dout_o   (sample_dout),
        .status_o (sample_status)
    );

    sample_packer u_packer (
        .clk_i           (adc_sampleclk),
        .reset           (path_reset),
        .state_i         (state),
        .sample_status_i (sample_status),
        .sample_i        (sample_dout),
        .word_status_i   (word_status),
        .sample_rd_o     (packer_rd),
        .word_wr_o       (word_wr),
        .word_o          (word_din),
        .idle_o          (packer_idle)
    );

    sample_fifo #(.payload_t(word_t), .DEPTH(`CAP_WORD_DEPTH)) u_word_fifo (
        .clk_i    (adc_sampleclk),
        .reset    (reset),
        .clear_i  (fifo_clear),
        .wr_en_i  (word_wr),
        .din_i    (word_din),
        .rd_en_i  (word_rd),
        .dout_o   (word_dout),
        .status_o (word_status)
    );

    byte_unpacker u_unpacker (
        .clk_i         (adc_sampleclk),
        .reset         (path_reset),
        .read_en_i     (read_en_i),
        .low_res_i     (low_res_i),
        .word_status_i (word_status),
        .word_i        (word_dout),
        .word_rd_o     (word_rd),
        .data_o        (read_data_o),
        .valid_o       (read_valid_o)
    );

endmodule

// File: hw/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import capture_pkg::*; #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic         clk_i,
    input  logic         reset,
    input  logic         clear_i,
    input  logic         wr_en_i,
    input  payload_t     din_i,
    input  logic         rd_en_i,
    output payload_t     dout_o,
    output fifo_status_t status_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign do_wr = wr_en_i & ~full;   // write into a full FIFO is dropped
    assign do_rd = rd_en_i & ~empty;

    assign status_o.empty = empty;
    assign status_o.full  = full;
    assign dout_o         = mem[rd_ptr];   // head entry, first word fall through

    always_ff @(posedge clk_i) begin
        if (reset || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_next(wr_ptr);
            if (do_rd) rd_ptr <= ptr_next(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) mem[wr_ptr] <= din_i;
    end

endmodule

// File: hw/sample_packer.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module sample_packer import capture_pkg::*; (
    input  logic           clk_i,
    input  logic           reset,
    input  capture_state_t state_i,
    input  fifo_status_t   sample_status_i,
    input  sample_t        sample_i,
    input  fifo_status_t   word_status_i,
    output logic           sample_rd_o,
    output logic           word_wr_o,
    output word_t          word_o,
    output logic           idle_o
);

    localparam int LAST  = `CAP_SAMPLES_PER_WORD - 1;
    localparam int CNT_W = $clog2(`CAP_SAMPLES_PER_WORD);

    logic [CNT_W-1:0] rd_cnt;   // samples already in the word register
    logic             wr_q;
    logic             capturing;
    logic             last_rd;
    word_t            word_q;

    assign capturing = (state_i == ST_TRIGGERED) || (state_i == ST_DONE);

    // word FIFO full stalls the packer
    assign sample_rd_o = capturing & ~sample_status_i.empty & ~word_status_i.full;
    assign last_rd     = sample_rd_o && (rd_cnt == CNT_W'(LAST));

    assign word_o    = word_q;
    assign word_wr_o = wr_q;
    assign idle_o    = (rd_cnt == '0) & ~wr_q;

    always_ff @(posedge clk_i) begin
        if (reset) begin
            rd_cnt <= '0;
            wr_q   <= 1'b0;
        end else begin
            wr_q <= last_rd;   // word goes out one cycle after the third read
            if (last_rd)
                rd_cnt <= '0;
            else if (sample_rd_o)
                rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // oldest sample ends up in the top bits
    always_ff @(posedge clk_i) begin
        if (sample_rd_o)
            word_q <= {word_q[`CAP_WORD_W-`CAP_SAMPLE_W-1:0], sample_i};
    end

endmodule

// File: sim/capture_checker.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module capture_checker import capture_pkg::*; (
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  sample_t      adc_datain_i,
    input  logic         adc_write_mask_i,
    input  logic         arm_i,
    input  logic         adc_capture_go_i,
    input  capture_cfg_t cfg_i,
    input  logic         low_res_i,
    input  byte_t        read_data_i,
    input  logic         read_valid_i,
    input  logic         read_empty_i,
    input  logic         capture_done_i,
    input  int           test_id_i,
    input  logic         check_i,
    output int           data_errs_o,
    output int           count_errs_o
);

    localparam int PAIR_W       = 2 * `CAP_WORD_W;
    localparam int PAIR_SAMPLES = 2 * `CAP_SAMPLES_PER_WORD;

    typedef enum int {M_IDLE, M_PRE, M_WAIT, M_TRIG, M_DONE} model_state_t;

    model_state_t            mstate;
    logic                    arm_q;
    logic                    reset_q;
    logic [`CAP_DECIM_W-1:0] decim_cnt;
    int                      stop_cnt;
    logic                    low_res_run;
    sample_t                 exp_q[$];   // expected samples, oldest first
    int                      rx_cnt;
    int                      done_rises;
    logic                    done_q;
    int                      data_errs = 0;
    int                      count_errs = 0;

    assign data_errs_o  = data_errs;
    assign count_errs_o = count_errs;

    function automatic string test_name(input int id);
        case (id)
            1:       return "full_res_no_pre";
            2:       return "presamples";
            3:       return "decim_mask";
            4:       return "low_res";
            5:       return "rearm";
            default: return "reset";
        endcase
    endfunction

    function automatic int expected_count();
        int words;
        words = exp_q.size() / `CAP_SAMPLES_PER_WORD;
        if (low_res_run) return exp_q.size();
        // an unpaired last word only gives its whole bytes
        return `CAP_BYTES_PER_PAIR * (words / 2) + (`CAP_WORD_W / 8) * (words % 2);
    endfunction

    function automatic byte_t expected_byte(input int idx);
        logic [PAIR_W-1:0] pair;
        sample_t           s;
        int                base;
        int                k;
        if (low_res_run) begin
            return (idx < exp_q.size()) ? exp_q[idx][`CAP_SAMPLE_W-1 -: 8] : 8'h00;
        end
        pair = '0;
        base = (idx / `CAP_BYTES_PER_PAIR) * PAIR_SAMPLES;
        for (k = 0; k < PAIR_SAMPLES; k++) begin
            s    = (base + k < exp_q.size()) ? exp_q[base + k] : '0;
            pair = {pair[PAIR_W-`CAP_SAMPLE_W-1:0], s};   // older sample higher up
        end
        return pair[PAIR_W - 1 - 8 * (idx % `CAP_BYTES_PER_PAIR) -: 8];
    endfunction

    always @(posedge adc_sampleclk) begin : model_step
        logic  elig;
        logic  take;
        byte_t exp_b;
        if (reset) begin
            if (reset_q && (read_valid_i || capture_done_i || !read_empty_i)) begin
                count_errs++;
                $display("%s: outputs not at their reset values during reset",
                         test_name(0));
            end
            reset_q     = 1'b1;
            arm_q       = arm_i;   // an arm held through reset is not an edge
            decim_cnt   = '0;
            mstate      = M_IDLE;
            stop_cnt    = 0;
            low_res_run = 1'b0;
            exp_q.delete();
            rx_cnt      = 0;
            done_rises  = 0;
            done_q      = 1'b0;
        end else begin
            reset_q = 1'b0;
            if (read_valid_i) begin
                if (rx_cnt >= expected_count()) begin
                    count_errs++;
                    $display("%s: byte 0x%02h arrived beyond the %0d expected bytes",
                             test_name(test_id_i), read_data_i, expected_count());
                end else begin
                    exp_b = expected_byte(rx_cnt);
                    if (exp_b !== read_data_i) begin
                        data_errs++;
                        $display("[ERROR] %s byte %0d: expected 0x%02h actual 0x%02h",
                                 test_name(test_id_i), rx_cnt, exp_b, read_data_i);
                    end
                end
                rx_cnt++;
            end

            if (capture_done_i && !done_q) done_rises++;
            done_q = capture_done_i;

            if (check_i) begin
                if (mstate != M_DONE) begin
                    count_errs++;
                    $display("%s: model capture never reached its stop count",
                             test_name(test_id_i));
                end
                if (rx_cnt != expected_count()) begin
                    count_errs++;
                    $display("[ERROR] %s byte count: expected %0d actual %0d",
                             test_name(test_id_i), expected_count(), rx_cnt);
                end
                if (done_rises != 1) begin
                    count_errs++;
                    $display("[ERROR] %s capture_done_o rises: expected 1 actual %0d",
                             test_name(test_id_i), done_rises);
                end
                if (!read_empty_i) begin
                    count_errs++;
                    $display("%s: read_empty_o is low after the last byte",
                             test_name(test_id_i));
                end
            end

            elig = (decim_cnt == cfg_i.decimation);
            if (arm_i && !arm_q) begin
                decim_cnt   = '0;
                exp_q.delete();
                rx_cnt      = 0;
                done_rises  = 0;
                stop_cnt    = ((int'(cfg_i.max_samples) + 2) / 3) * 3;
                low_res_run = low_res_i;
                mstate      = (cfg_i.presamples != '0) ? M_PRE : M_WAIT;
            end else begin
                decim_cnt = elig ? '0 : decim_cnt + 1'b1;
                take      = elig && adc_write_mask_i;
                case (mstate)
                    M_PRE: begin
                        if (take) begin
                            exp_q.push_back(adc_datain_i);
                            // rolling window keeps the newest presamples
                            if (exp_q.size() > int'(cfg_i.presamples))
                                void'(exp_q.pop_front());
                        end
                        if (adc_capture_go_i) mstate = M_TRIG;
                    end
                    M_WAIT: begin
                        if (adc_capture_go_i) mstate = M_TRIG;   // no sample on this edge
                    end
                    M_TRIG: begin
                        if (exp_q.size() >= stop_cnt && exp_q.size() % 3 == 0)
                            mstate = M_DONE;
                        else if (take)
                            exp_q.push_back(adc_datain_i);
                    end
                    default: ;
                endcase
            end
            arm_q = arm_i;
        end
    end

endmodule

// File: sim/capture_tb.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module capture_tb import capture_pkg::*; ();

    localparam int DONE_TIMEOUT  = 2000;
    localparam int EMPTY_TIMEOUT = 1000;

    logic         adc_sampleclk;
    logic         reset;
    sample_t      adc_datain;
    logic         adc_write_mask;
    logic         arm;
    logic         capture_go;
    capture_cfg_t cfg;
    logic         low_res;
    logic         read_en;
    byte_t        read_data;
    logic         read_valid;
    logic         read_empty;
    logic         capture_done;

    logic [31:0]  lfsr_q;
    logic         mask_random;   // random mask bits, else all samples masked in
    int           test_id;
    logic         check_run;
    int           timeout_errs;
    int           data_errs;
    int           count_errs;
    int           run;

    capture_top DUT (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .adc_datain_i     (adc_datain),
        .adc_write_mask_i (adc_write_mask),
        .arm_i            (arm),
        .adc_capture_go_i (capture_go),
        .cfg_i            (cfg),
        .low_res_i        (low_res),
        .read_en_i        (read_en),
        .read_data_o      (read_data),
        .read_valid_o     (read_valid),
        .read_empty_o     (read_empty),
        .capture_done_o   (capture_done)
    );

    capture_checker u_capture_checker (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .adc_datain_i     (adc_datain),
        .adc_write_mask_i (adc_write_mask),
        .arm_i            (arm),
        .adc_capture_go_i (capture_go),
        .cfg_i            (cfg),
        .low_res_i        (low_res),
        .read_data_i      (read_data),
        .read_valid_i     (read_valid),
        .read_empty_i     (read_empty),
        .capture_done_i   (capture_done),
        .test_id_i        (test_id),
        .check_i          (check_run),
        .data_errs_o      (data_errs),
        .count_errs_o     (count_errs)
    );

    always #4 adc_sampleclk = ~adc_sampleclk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // one clock, then fresh ADC data just after the edge
    task automatic step();
        @(posedge adc_sampleclk);
        #1;
        adc_datain     = sample_t'(take_bits(`CAP_SAMPLE_W));
        adc_write_mask = mask_random ? (take_bits(2) != 0) : 1'b1;   // about 3 of 4 kept
    endtask

    task automatic wait_done(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < DONE_TIMEOUT && !ok; n++) begin
            step();
            ok = capture_done;
        end
        if (!ok) begin
            timeout_errs++;
            $display("test %0d: capture_done_o did not rise within %0d cycles",
                     test_id, DONE_TIMEOUT);
        end
    endtask

    task automatic wait_empty(output logic ok);
        int n;
        ok = read_empty;
        for (n = 0; n < EMPTY_TIMEOUT && !ok; n++) begin
            step();
            ok = read_empty;
        end
        if (!ok) begin
            timeout_errs++;
            $display("test %0d: word FIFO did not drain within %0d cycles",
                     test_id, EMPTY_TIMEOUT);
        end
    endtask

    task automatic run_capture(input int id, input logic low_sel, input logic no_pre,
                               input logic rand_mask);
        capture_cfg_t cfg_next;
        int           trig_wait;
        int           n;
        logic         ok;
        test_id     = id;
        mask_random = rand_mask;
        cfg_next.decimation  = `CAP_DECIM_W'(take_bits(2));
        cfg_next.presamples  = no_pre ? '0 : `CAP_COUNT_W'(take_bits(5) % 21);
        cfg_next.max_samples = `CAP_COUNT_W'(take_bits(6) % 60 + 1);
        trig_wait            = int'(take_bits(6));
        cfg     = cfg_next;
        low_res = low_sel;
        arm     = 1'b1;
        step();
        arm = 1'b0;
        for (n = 0; n < trig_wait; n++) step();
        capture_go = 1'b1;
        wait_done(ok);
        capture_go = 1'b0;
        if (ok) wait_empty(ok);
        if (ok) begin
            repeat (8) step();   // quiet window, nothing may trail the last byte
            check_run = 1'b1;
            step();
            check_run = 1'b0;
        end
    endtask

    // arm and fill presamples, then abandon the run without a trigger
    task automatic abort_arm();
        int n;
        test_id        = 5;
        cfg.presamples = 16'd20;
        arm            = 1'b1;
        step();
        arm = 1'b0;
        for (n = 0; n < 12; n++) step();
    endtask

    initial begin
        lfsr_q         = 32'he29b_3e60;
        adc_sampleclk  = 1'b0;
        reset          = 1'b1;
        adc_datain     = '0;
        adc_write_mask = 1'b0;
        arm            = 1'b0;
        capture_go     = 1'b0;
        cfg            = '0;
        low_res        = 1'b0;
        read_en        = 1'b0;
        mask_random    = 1'b0;
        test_id        = 0;
        check_run      = 1'b0;
        timeout_errs   = 0;

        repeat (16) @(posedge adc_sampleclk);
        #1;
        reset   = 1'b0;
        read_en = 1'b1;   // output side always drains

        for (run = 0; run < 3 && timeout_errs == 0; run++) run_capture(1, 1'b0, 1'b1, 1'b0);
        for (run = 0; run < 4 && timeout_errs == 0; run++) run_capture(2, 1'b0, 1'b0, 1'b0);
        for (run = 0; run < 4 && timeout_errs == 0; run++) run_capture(3, 1'b0, 1'b0, 1'b1);
        for (run = 0; run < 3 && timeout_errs == 0; run++) run_capture(4, 1'b1, 1'b0, 1'b1);
        for (run = 0; run < 3 && timeout_errs == 0; run++) begin
            abort_arm();
            run_capture(5, run[0], 1'b0, 1'b1);
            if (timeout_errs == 0) run_capture(5, ~run[0], 1'b0, 1'b1);   // back to back
        end

        $display("errors: data %0d, count %0d, timeout %0d",
                 data_errs, count_errs, timeout_errs);
        if (data_errs + count_errs + timeout_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
